// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  import rv_pkg::*;

  // --------------------
  // Timing and budget
  // --------------------
  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int PROG_CYCLES   = 200;
  localparam int SETTLE_CYCLES = 4;
  localparam int NUM_PROGRAMS  = 6;
  localparam int WATCHDOG_NS   =
    NUM_PROGRAMS * (RESET_CYCLES + PROG_CYCLES + SETTLE_CYCLES + 4) * CLK_PERIOD;

  // RV32I major opcodes and fixed words
  localparam logic [6:0] OP_R    = 7'b0110011;
  localparam logic [6:0] OP_I    = 7'b0010011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam word_t EBREAK_WORD  = 32'h0010_0073;
  localparam word_t ILLEGAL_WORD = 32'hffff_ffff;

  logic  clk = 1'b0;
  logic  rst_n = 1'b0;
  logic  imem_arvalid;
  word_t imem_araddr;
  word_t imem_rdata;
  logic  dmem_ren;
  word_t dmem_raddr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_waddr;
  word_t dmem_wdata;
  logic  ebreak;
  logic  trap;

  word_t  imem [0:255];
  word_t  dmem [0:255];
  word_t  prog [$];
  // Stores still to come in program order
  word_t  exp_addr [$];
  word_t  exp_data [$];
  // Load addresses still to come
  word_t  exp_raddr [$];
  string  test_name = "idle";
  integer seed = 32'h2d956ddc;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Zero-latency memories
  assign imem_rdata = imem[imem_araddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  rv_core #(
    .RESET_PC(32'h0)
  ) rv_core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr),
    .imem_rdata  (imem_rdata),
    .dmem_ren    (dmem_ren),
    .dmem_raddr  (dmem_raddr),
    .dmem_rdata  (dmem_rdata),
    .dmem_we     (dmem_we),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .ebreak      (ebreak),
    .trap        (trap)
  );

  // --------------------
  // Failure reporting
  // --------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      stop_with_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_flags(input string name, input logic exp_eb, input logic exp_tr,
                             input logic act_eb, input logic act_tr);
    if ((exp_eb !== act_eb) || (exp_tr !== act_tr)) begin
      stop_with_failure($sformatf(
        "ERROR %s flags: expected ebreak=%b trap=%b, actual ebreak=%b trap=%b",
        name, exp_eb, exp_tr, act_eb, act_tr));
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_XOR:    return a ^ b;
      ALU_SLL:    return a << b[4:0];
      ALU_SRL:    return a >> b[4:0];
      // Logical shift with the vacated upper bits filled from the sign
      ALU_SRA:    return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      // Signed compare by flipping the sign bits
      ALU_SLT:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
      ALU_PASS_B: return b;
      default:    return 32'd0;
    endcase
  endfunction

  // {funct7, funct3} of each operation in the OP space
  function automatic logic [9:0] funct_of(input alu_op_e op);
    case (op)
      ALU_ADD:  return {7'h00, 3'b000};
      ALU_SUB:  return {7'h20, 3'b000};
      ALU_SLL:  return {7'h00, 3'b001};
      ALU_SLT:  return {7'h00, 3'b010};
      ALU_SLTU: return {7'h00, 3'b011};
      ALU_XOR:  return {7'h00, 3'b100};
      ALU_SRL:  return {7'h00, 3'b101};
      ALU_SRA:  return {7'h20, 3'b101};
      ALU_OR:   return {7'h00, 3'b110};
      ALU_AND:  return {7'h00, 3'b111};
      default:  return 10'h000;
    endcase
  endfunction

  function automatic word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // --------------------
  // Program assembler
  // --------------------
  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // Branch offset bits land scattered over the word
  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(input logic [19:0] upper, input reg_idx_t rd);
    return {upper, rd, 7'b0110111};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  // LUI plus ADDI with the upper part rounded for the signed low half
  task automatic load_const(input reg_idx_t rd, input word_t v);
    word_t upper;
    upper = (v + 32'h800) >> 12;
    emit(enc_u(upper[19:0], rd));
    emit(enc_i(v[11:0], rd, 3'b000, rd, OP_I));
  endtask

  task automatic store_word(input reg_idx_t rs2, input logic [11:0] off);
    emit(enc_s(off, rs2, 5'd0));
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic expect_load(input word_t addr);
    exp_raddr.push_back(addr);
  endtask

  // --------------------
  // Data memory monitor
  // --------------------
  // Each read and write is compared in order, then writes go into the data memory
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 256; k++) begin
        dmem[k] <= 32'h5a5a_0000 ^ (word_t'(k) << 2);
      end
    end else begin
      if (dmem_ren) begin
        if (exp_raddr.size() == 0) begin
          stop_with_failure($sformatf("%s: unexpected load from address %h",
                                      test_name, dmem_raddr));
        end else begin
          check_word({test_name, " load address"}, exp_raddr[0], dmem_raddr);
          void'(exp_raddr.pop_front());
        end
      end
      if (dmem_we) begin
        if (exp_addr.size() == 0) begin
          stop_with_failure($sformatf("%s: unexpected store of %h to address %h",
                                      test_name, dmem_wdata, dmem_waddr));
        end else begin
          check_word({test_name, " store address"}, exp_addr[0], dmem_waddr);
          check_word({test_name, " store data"}, exp_data[0], dmem_wdata);
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
        dmem[dmem_waddr[9:2]] <= dmem_wdata;
      end
    end
  end

  // --------------------
  // Program runner
  // --------------------
  task automatic run_program(input string name, input logic exp_eb, input logic exp_tr);
    word_t fill_addr;
    int    cycles;
    test_name = name;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    // Unused words decode as illegal and each one differs
    for (int k = 0; k < 256; k++) begin
      fill_addr = word_t'(k) << 2;
      imem[k] = {fill_addr[24:0], 7'b0000000};
    end
    for (int k = 0; k < prog.size(); k++) begin
      imem[k] = prog[k];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Fetch runs and the sticky flags are clear right out of reset
    check_bit({name, " fetch enable after reset"}, 1'b1, imem_arvalid);
    check_flags({name, " after reset"}, 1'b0, 1'b0, ebreak, trap);
    cycles = 0;
    while (!(ebreak || trap) && (cycles < PROG_CYCLES)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!(ebreak || trap)) begin
      stop_with_failure($sformatf("%s: core did not halt within %0d cycles",
                                  name, PROG_CYCLES));
    end
    // Give any late store a chance to show up
    repeat (SETTLE_CYCLES) @(posedge clk);
    #1;
    check_word({name, " missing stores"}, 32'd0, word_t'(exp_addr.size()));
    check_word({name, " missing loads"}, 32'd0, word_t'(exp_raddr.size()));
    check_flags(name, exp_eb, exp_tr, ebreak, trap);
    check_bit({name, " fetch enable after halt"}, 1'b0, imem_arvalid);
    prog.delete();
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reg_alu();
    alu_op_e    op;
    logic [9:0] fn;
    word_t      a;
    word_t      b;
    word_t      addr;
    for (int k = 0; k < 10; k++) begin
      op   = alu_op_e'(k[3:0]);
      fn   = funct_of(op);
      a    = $random(seed);
      b    = $random(seed);
      addr = 32'h100 + (word_t'(k) << 2);
      load_const(5'd1, a);
      load_const(5'd2, b);
      // Result feeds the store right behind it
      emit(enc_r(fn[9:3], 5'd2, 5'd1, fn[2:0], 5'd3));
      store_word(5'd3, addr[11:0]);
      expect_store(addr, ref_alu(op, a, b));
    end
    emit(EBREAK_WORD);
    run_program("reg_alu", 1'b1, 1'b0);
  endtask

  task automatic test_imm_alu();
    alu_op_e     op;
    logic [9:0]  fn;
    logic [11:0] imm12;
    word_t       a;
    word_t       rnd;
    word_t       addr;
    for (int k = 0; k < 10; k++) begin
      op   = alu_op_e'(k[3:0]);
      fn   = funct_of(op);
      a    = $random(seed);
      rnd  = $random(seed);
      addr = 32'h100 + (word_t'(k) << 2);
      // No SUBI in RV32I
      if (op != ALU_SUB) begin
        if ((op == ALU_SLL) || (op == ALU_SRL) || (op == ALU_SRA)) begin
          imm12 = {fn[9:3], rnd[4:0]};
        end else begin
          imm12 = rnd[11:0];
        end
        load_const(5'd1, a);
        emit(enc_i(imm12, 5'd1, fn[2:0], 5'd3, OP_I));
        store_word(5'd3, addr[11:0]);
        expect_store(addr, ref_alu(op, a, sext12(imm12)));
      end
    end
    // LUI takes the slot SUB left free
    rnd = $random(seed);
    emit(enc_u(rnd[19:0], 5'd4));
    store_word(5'd4, 12'h104);
    expect_store(32'h104, ref_alu(ALU_PASS_B, 32'd0, {rnd[19:0], 12'h000}));
    emit(EBREAK_WORD);
    run_program("imm_alu", 1'b1, 1'b0);
  endtask

  task automatic test_load_store();
    word_t v;
    v = $random(seed);
    load_const(5'd5, v);
    store_word(5'd5, 12'h200);
    emit(enc_i(12'h200, 5'd0, 3'b010, 5'd6, OP_LOAD));
    store_word(5'd6, 12'h204);
    emit(EBREAK_WORD);
    expect_store(32'h200, v);
    expect_load(32'h200);
    expect_store(32'h204, v);
    run_program("load_store", 1'b1, 1'b0);
  endtask

  task automatic test_control();
    word_t jal_pc;
    emit(enc_i(12'h011, 5'd0, 3'b000, 5'd1, OP_I));
    emit(enc_i(12'h011, 5'd0, 3'b000, 5'd2, OP_I));
    // Taken BEQ jumps over the first store
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
    store_word(5'd1, 12'h300);
    emit(enc_i(12'h022, 5'd0, 3'b000, 5'd3, OP_I));
    // Equal operands so BNE falls through
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    store_word(5'd3, 12'h304);
    jal_pc = word_t'(prog.size()) << 2;
    emit(enc_j(21'd8, 5'd4));
    store_word(5'd0, 12'h308);
    store_word(5'd4, 12'h30c);
    emit(EBREAK_WORD);
    expect_store(32'h304, 32'h22);
    expect_store(32'h30c, jal_pc + 32'd4);
    run_program("control", 1'b1, 1'b0);
  endtask

  task automatic test_halt(input logic use_ebreak);
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd1, OP_I));
    store_word(5'd1, 12'h380);
    emit(use_ebreak ? EBREAK_WORD : ILLEGAL_WORD);
    // Nothing past the halting word may retire
    store_word(5'd1, 12'h384);
    store_word(5'd1, 12'h388);
    emit(EBREAK_WORD);
    expect_store(32'h380, 32'h55);
    if (use_ebreak) begin
      run_program("halt_ebreak", 1'b1, 1'b0);
    end else begin
      run_program("halt_trap", 1'b0, 1'b1);
    end
  endtask

  // --------------------
  // Main sequence and watchdog
  // --------------------
  initial begin
    test_reg_alu();
    test_imm_alu();
    test_load_store();
    test_control();
    test_halt(1'b1);
    test_halt(1'b0);
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Watchdog expired before all test programs finished");
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=rv_core_sim

if ! verilator --binary --timing --timescale 1ns/1ps \
    --top-module rv_core_tb \
    -f rv_core.f \
    -Mdir "${BUILD_DIR}" -o "${SIM_BIN}"; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./${BUILD_DIR}/${SIM_BIN}"; then
  echo "Simulation reported a failure"
  exit 1
fi

exit 0

// ==== rv_core.f ====
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_memwb.sv
source/rv_hazard.sv
source/rv_core.sv
bench/rv_core_tb.sv

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst_n,
  output logic          imem_arvalid,
  output rv_pkg::word_t imem_araddr,
  input  rv_pkg::word_t imem_rdata,
  output logic          dmem_ren,
  output rv_pkg::word_t dmem_raddr,
  input  rv_pkg::word_t dmem_rdata,
  output logic          dmem_we,
  output rv_pkg::word_t dmem_waddr,
  output rv_pkg::word_t dmem_wdata,
  output logic          ebreak,
  output logic          trap
);

  import rv_pkg::*;

  // --------------------
  // Stage registers
  // --------------------
  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_wb_t   ex_wb;

  // Hazard inputs from ID and EX
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     rs1_used;
  logic     rs2_used;
  reg_idx_t ex_rd;
  logic     ex_reg_write;

  // Redirect from EX
  logic     redirect;
  word_t    redirect_pc;

  // Write-back into the register file
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // Pipeline control
  logic     stall;
  logic     flush;
  logic     halted;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .flush       (flush),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr),
    .imem_rdata  (imem_rdata),
    .if_id       (if_id)
  );

  rv_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .if_id   (if_id),
    .stall   (stall),
    .flush   (flush),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_used(rs1_used),
    .rs2_used(rs2_used),
    .id_ex   (id_ex)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_ex       (id_ex),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_rd       (ex_rd),
    .ex_reg_write(ex_reg_write),
    .ex_wb       (ex_wb)
  );

  rv_memwb u_memwb (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_wb     (ex_wb),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  rv_hazard u_hazard (
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_used    (rs1_used),
    .rs2_used    (rs2_used),
    .ex_rd       (ex_rd),
    .ex_reg_write(ex_reg_write),
    .redirect    (redirect),
    .halted      (halted),
    .stall       (stall),
    .flush       (flush)
  );

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::if_id_t   if_id,
  input  logic             stall,
  input  logic             flush,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::word_t    wb_data,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output logic             rs1_used,
  output logic             rs2_used,
  output rv_pkg::id_ex_t   id_ex
);

  import rv_pkg::*;

  instr_u ins;
  ctrl_t  ctrl;
  word_t  imm;
  logic   use1;
  logic   use2;
  word_t  rs1_data;
  word_t  rs2_data;

  // x1..x31 only, x0 reads as zero
  word_t  regs [1:31];

  assign ins = if_id.instr;
  assign rs1 = ins.r_fmt.rs1;
  assign rs2 = ins.r_fmt.rs2;

  // Only a live instruction may cause an interlock
  assign rs1_used = use1 && if_id.valid;
  assign rs2_used = use2 && if_id.valid;

  // --------------------
  // Control decode
  // --------------------
  always_comb begin
    ctrl = '0;
    imm  = '0;
    use1 = 1'b0;
    use2 = 1'b0;
    case (opcode_e'(ins.r_fmt.opcode))
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        use1 = 1'b1;
        use2 = 1'b1;
        case ({ins.r_fmt.funct7, ins.r_fmt.funct3})
          {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
          default:         ctrl.is_illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use1 = 1'b1;
        imm  = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
        case (ins.i_fmt.funct3)
          3'b000: ctrl.alu_op = ALU_ADD;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b111: ctrl.alu_op = ALU_AND;
          // Shift amounts sit in imm[4:0], upper bits pick the variant
          3'b001: begin
            if (ins.r_fmt.funct7 == 7'h00) ctrl.alu_op = ALU_SLL;
            else ctrl.is_illegal = 1'b1;
          end
          default: begin
            if (ins.r_fmt.funct7 == 7'h00) ctrl.alu_op = ALU_SRL;
            else if (ins.r_fmt.funct7 == 7'h20) ctrl.alu_op = ALU_SRA;
            else ctrl.is_illegal = 1'b1;
          end
        endcase
      end
      OPC_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_PASS_B;
        imm = {if_id.instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        // Word loads only
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.is_illegal  = (ins.i_fmt.funct3 != 3'b010);
        use1 = 1'b1;
        imm  = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
      end
      OPC_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.is_illegal  = (ins.s_fmt.funct3 != 3'b010);
        use1 = 1'b1;
        use2 = 1'b1;
        imm  = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
      end
      OPC_BRANCH: begin
        // BEQ and BNE differ only in funct3[0]
        ctrl.is_branch  = 1'b1;
        ctrl.branch_ne  = ins.b_fmt.funct3[0];
        ctrl.is_illegal = (ins.b_fmt.funct3[2:1] != 2'b00);
        use1 = 1'b1;
        use2 = 1'b1;
        imm  = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        imm = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
               ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
      end
      OPC_SYSTEM: begin
        if (if_id.instr == EBREAK_INSN) ctrl.is_ebreak = 1'b1;
        else ctrl.is_illegal = 1'b1;
      end
      default: ctrl.is_illegal = 1'b1;
    endcase

    // An illegal word must not write anything or read sources
    if (ctrl.is_illegal) begin
      ctrl = '0;
      ctrl.is_illegal = 1'b1;
      use1 = 1'b0;
      use2 = 1'b0;
    end
  end

  // --------------------
  // Register file
  // --------------------
  always_ff @(posedge clk) begin
    if (wb_en && (wb_rd != 5'd0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle write is visible to the read
  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (wb_en && (wb_rd == rs1)) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (wb_en && (wb_rd == rs2)) ? wb_data : regs[rs2];

  // --------------------
  // ID/EX register
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      // Bubble on interlock or redirect
      id_ex.valid    <= if_id.valid && !stall && !flush;
      id_ex.pc       <= if_id.pc;
      id_ex.ctrl     <= ctrl;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
      id_ex.rd       <= ins.r_fmt.rd;
    end
  end

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::id_ex_t   id_ex,
  output logic             redirect,
  output rv_pkg::word_t    redirect_pc,
  output rv_pkg::reg_idx_t ex_rd,
  output logic             ex_reg_write,
  output rv_pkg::ex_wb_t   ex_wb
);

  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_res;
  logic  equal;
  logic  taken;

  assign op_a = id_ex.rs1_data;
  assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_data;

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      // Shift amount is the low five bits
      ALU_SLL:    alu_res = op_a << op_b[4:0];
      ALU_SRL:    alu_res = op_a >> op_b[4:0];
      ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // --------------------
  // Branch and jump
  // --------------------
  // BNE inverts the equality result
  assign equal = (id_ex.rs1_data == id_ex.rs2_data);
  assign taken = id_ex.ctrl.is_branch && (equal ^ id_ex.ctrl.branch_ne);

  // Both targets are pc relative
  assign redirect    = id_ex.valid && (taken || id_ex.ctrl.is_jal);
  assign redirect_pc = id_ex.pc + id_ex.imm;

  // Destination seen by the interlock
  assign ex_rd        = id_ex.rd;
  assign ex_reg_write = id_ex.valid && id_ex.ctrl.reg_write;

  // --------------------
  // EX/WB register
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_wb.valid <= 1'b0;
    end else begin
      ex_wb.valid      <= id_ex.valid;
      ex_wb.ctrl       <= id_ex.ctrl;
      // JAL links to the next sequential address
      ex_wb.result     <= id_ex.ctrl.is_jal ? (id_ex.pc + 32'd4) : alu_res;
      ex_wb.store_data <= id_ex.rs2_data;
      ex_wb.rd         <= id_ex.rd;
    end
  end

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           flush,
  input  rv_pkg::word_t  redirect_pc,
  input  logic           halted,
  output logic           imem_arvalid,
  output rv_pkg::word_t  imem_araddr,
  input  rv_pkg::word_t  imem_rdata,
  output rv_pkg::if_id_t if_id
);

  import rv_pkg::*;

  word_t pc;

  // Fetch stops for good once the core halts
  assign imem_arvalid = !halted;
  assign imem_araddr  = pc;

  // --------------------
  // Program counter
  // --------------------
  // Redirect beats stall, halt freezes everything
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halted) begin
      if (flush) begin
        pc <= redirect_pc;
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  // --------------------
  // IF/ID register
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else if (flush || halted) begin
      // Drop the wrong-path word, or anything fetched after halt
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_rdata;
    end
  end

endmodule

// ==== source/rv_hazard.sv ====
`timescale 1ns/1ps

module rv_hazard (
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             rs1_used,
  input  logic             rs2_used,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             ex_reg_write,
  input  logic             redirect,
  input  logic             halted,
  output logic             stall,
  output logic             flush
);

  import rv_pkg::*;

  logic rs1_hit;
  logic rs2_hit;
  logic ex_writes;

  // --------------------
  // Read-after-write interlock
  // --------------------
  // x0 never carries a dependency
  assign ex_writes = ex_reg_write && (ex_rd != reg_idx_t'(0));

  assign rs1_hit = rs1_used && (rs1 == ex_rd);
  assign rs2_hit = rs2_used && (rs2 == ex_rd);

  // One cycle is enough since WB bypasses into the read
  assign stall = !halted && ex_writes && (rs1_hit || rs2_hit);

  // Taken branch or JAL kills the two younger slots
  assign flush = redirect;

endmodule

// ==== source/rv_memwb.sv ====
`timescale 1ns/1ps

module rv_memwb (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::ex_wb_t   ex_wb,
  output logic             dmem_ren,
  output rv_pkg::word_t    dmem_raddr,
  input  rv_pkg::word_t    dmem_rdata,
  output logic             dmem_we,
  output rv_pkg::word_t    dmem_waddr,
  output rv_pkg::word_t    dmem_wdata,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output logic             halted,
  output logic             ebreak,
  output logic             trap
);

  import rv_pkg::*;

  logic retire;

  // Nothing retires after a halt
  assign retire = ex_wb.valid && !halted;

  // --------------------
  // Data memory
  // --------------------
  // Zero-latency memory, read data comes back this cycle
  assign dmem_ren   = retire && ex_wb.ctrl.mem_read;
  assign dmem_raddr = ex_wb.result;
  assign dmem_we    = retire && ex_wb.ctrl.mem_write;
  assign dmem_waddr = ex_wb.result;
  assign dmem_wdata = ex_wb.store_data;

  // --------------------
  // Write-back
  // --------------------
  assign wb_en   = retire && ex_wb.ctrl.reg_write;
  assign wb_rd   = ex_wb.rd;
  assign wb_data = ex_wb.ctrl.mem_read ? dmem_rdata : ex_wb.result;

  // Sticky flags, cleared only by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      halted <= halted || (retire && (ex_wb.ctrl.is_ebreak || ex_wb.ctrl.is_illegal));
      ebreak <= ebreak || (retire && ex_wb.ctrl.is_ebreak);
      trap   <= trap || (retire && ex_wb.ctrl.is_illegal);
    end
  end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

  // --------------------
  // Widths and basic types
  // --------------------
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Only exact encoding of EBREAK in the SYSTEM space
  localparam word_t EBREAK_INSN = 32'h0010_0073;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations, ADD is zero so a cleared control word adds
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // --------------------
  // Instruction formats
  // --------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scrambled across the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One fetched word, seen through each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // --------------------
  // Control and stage registers
  // --------------------
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jal;
    logic    alu_src_imm;
    alu_op_e alu_op;
    logic    is_ebreak;
    logic    is_illegal;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rd;
  } id_ex_t;

  // Result holds the ALU value, or the link address for JAL
  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    result;
    word_t    store_data;
    reg_idx_t rd;
  } ex_wb_t;

endpackage
